// ==== ecc_scrub_bank_top.f ====
src/ecc_scrub_pkg.sv
src/secded_enc.sv
src/secded_dec.sv
src/ecc_scrubber.sv
src/ecc_bank.sv
src/ecc_scrub_bank_top.sv
verification/tb_clk_gen.sv
verification/tb_checker.sv
verification/tb_ecc_scrub.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the scrub bank testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 \
  -f ecc_scrub_bank_top.f \
  --top-module tb_ecc_scrub

out=$(./obj_dir/Vtb_ecc_scrub)
echo "$out"

if echo "$out" | grep -q "\*\*\* TEST PASSED \*\*\*"; then
  exit 0
fi
exit 1

// ==== verification/tb_ecc_scrub.sv ====
//////////////////////////////
// Scrub bank testbench top
//////////////////////////////

module tb_ecc_scrub;
  timeunit 1ns;
  timeprecision 1ps;
  import ecc_scrub_pkg::*;

  localparam int unsigned N = 64;
  localparam int Pass = 3 * N;
  // Sum of phase lengths plus margin
  localparam int TimeoutCycles = 2 * N + 3 * (4 * N + 20) + 3 * Pass + N + 500;

  logic        clk;
  logic        rst_n;
  logic        scrub_trigger;
  bank_req_t   intc_req;
  codeword_t   intc_rdata;
  logic        bit_corrected;
  logic        uncorrectable;
  logic [2:0]  phase;
  logic        pass_done;
  int          check_cnt;
  int          err_cnt;
  logic [31:0] rnd;

  tb_clk_gen #(.PeriodNs(40), .ResetCycles(4)) i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  ecc_scrub_bank_top #(.BankSize(N)) dut_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .scrub_trigger_i(scrub_trigger),
    .intc_req_i     (intc_req),
    .intc_rdata_o   (intc_rdata),
    .bit_corrected_o(bit_corrected),
    .uncorrectable_o(uncorrectable)
  );

  tb_checker #(.BankSize(N)) i_checker (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .intc_req_i     (intc_req),
    .intc_rdata_i   (intc_rdata),
    .bit_corrected_i(bit_corrected),
    .uncorrectable_i(uncorrectable),
    .phase_i        (phase),
    .pass_done_i    (pass_done),
    .check_cnt_o    (check_cnt),
    .err_cnt_o      (err_cnt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic drive(input logic req, input logic we, input int addr, input codeword_t cw);
    @(posedge clk);
    intc_req <= '{req: req, we: we, addr: 16'(addr), wdata: cw};
  endtask

  // Fresh random data with zero, one or two flipped bits
  task automatic write_random(input int addr, input int flips);
    codeword_t cw;
    int        b1;
    int        b2;
    rnd = xorshift32(rnd);
    cw  = i_checker.ref_encode(rnd);
    rnd = xorshift32(rnd);
    b1  = int'(rnd % 39);
    b2  = (b1 + 1 + int'((rnd >> 8) % 38)) % 39;
    if (flips > 0) cw[b1] = ~cw[b1];
    if (flips > 1) cw[b2] = ~cw[b2];
    drive(1'b1, 1'b1, addr, cw);
  endtask

  task automatic read_all();
    for (int a = 0; a < N; a++) drive(1'b1, 1'b0, a, '0);
    repeat (2) drive(1'b0, 1'b0, 0, '0);
  endtask

  task automatic signal_pass();
    @(posedge clk);
    pass_done <= 1'b1;
    @(posedge clk);
    pass_done <= 1'b0;
  endtask

  // Exactly one visit per address when started from Idle
  task automatic scrub_pass();
    @(posedge clk);
    scrub_trigger <= 1'b1;
    repeat (Pass) @(posedge clk);
    scrub_trigger <= 1'b0;
    signal_pass();
  endtask

  initial begin : proc_stimulus
    scrub_trigger = 1'b0;
    intc_req      = '0;
    phase         = 3'd0;
    pass_done     = 1'b0;
    rnd           = 32'hf26;
    @(posedge rst_n);
    // Round trip
    phase <= 3'd1;
    for (int a = 0; a < N; a++) write_random(a, 0);
    read_all();
    // Single-error correction
    phase <= 3'd2;
    for (int i = 0; i < 8; i++) write_random(i * 7, 1);
    drive(1'b0, 1'b0, 0, '0);
    scrub_pass();
    read_all();
    // Double errors
    phase <= 3'd3;
    for (int i = 0; i < 6; i++) write_random(i * 7 + 2, 2);
    drive(1'b0, 1'b0, 0, '0);
    scrub_pass();
    read_all();
    // Trigger off
    phase <= 3'd4;
    for (int i = 0; i < 5; i++) write_random(i * 7 + 4, 1);
    drive(1'b0, 1'b0, 0, '0);
    repeat (Pass) @(posedge clk);
    signal_pass();
    read_all();
    // Interference, random reads while scrubbing
    phase <= 3'd5;
    for (int i = 0; i < 4; i++) write_random(i * 9 + 1, 1);
    @(posedge clk);
    scrub_trigger <= 1'b1;
    intc_req      <= '0;
    for (int c = 0; c < 2 * Pass; c++) begin
      rnd = xorshift32(rnd);
      drive(rnd[31], 1'b0, int'(rnd % N), '0);
    end
    drive(1'b0, 1'b0, 0, '0);
    // Full pass from any FSM state
    repeat (Pass + 3) @(posedge clk);
    scrub_trigger <= 1'b0;
    repeat (3) @(posedge clk);
    signal_pass();
    phase <= 3'd6;
    read_all();
    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin : proc_watchdog
    repeat (TimeoutCycles) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== verification/tb_checker.sv ====
//////////////////////////////
// Scrub bank checker
// Shadow model and reference SECDED
//////////////////////////////

module tb_checker #(
  parameter int unsigned BankSize = 64
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  ecc_scrub_pkg::bank_req_t intc_req_i,
  input  ecc_scrub_pkg::codeword_t intc_rdata_i,
  input  logic                     bit_corrected_i,
  input  logic                     uncorrectable_i,
  input  logic [2:0]               phase_i,
  input  logic                     pass_done_i,
  output int                       check_cnt_o,
  output int                       err_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import ecc_scrub_pkg::*;

  // Phase codes shared with the stimulus
  localparam logic [2:0] PhTrigOff = 3'd4;
  localparam logic [2:0] PhInterf  = 3'd5;

  // Hsiao H-matrix data columns, check bits use unit columns
  localparam logic [6:0] HCol [32] = '{
    7'h07, 7'h0b, 7'h13, 7'h23, 7'h43, 7'h0d, 7'h15, 7'h25,
    7'h45, 7'h19, 7'h29, 7'h49, 7'h31, 7'h51, 7'h61, 7'h0e,
    7'h16, 7'h26, 7'h46, 7'h1a, 7'h2a, 7'h4a, 7'h32, 7'h52,
    7'h62, 7'h1c, 7'h2c, 7'h4c, 7'h34, 7'h54, 7'h64, 7'h38
  };

  codeword_t shadow [BankSize];
  logic      rd_pending;
  int        rd_addr;
  int        corr_cnt;
  int        uncorr_cnt;

  function automatic codeword_t ref_encode(input data_t d);
    logic [6:0] p;
    p = '0;
    for (int j = 0; j < 32; j++) begin
      if (d[j]) p ^= HCol[j];
    end
    return {p, d};
  endfunction

  function automatic logic [6:0] ref_syndrome(input codeword_t cw);
    codeword_t clean;
    clean = ref_encode(cw[31:0]);
    return clean[38:32] ^ cw[38:32];
  endfunction

  // Corrected word for an odd syndrome, otherwise unchanged
  function automatic codeword_t ref_scrub(input codeword_t cw);
    logic [6:0] syn;
    data_t      d;
    syn = ref_syndrome(cw);
    d   = cw[31:0];
    if (!(^syn)) return cw;
    for (int j = 0; j < 32; j++) begin
      if (syn == HCol[j]) d[j] = ~d[j];
    end
    return ref_encode(d);
  endfunction

  task automatic report_error(input string msg);
    err_cnt_o++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  // Pulse totals for one pass against the error classes in the shadow
  task automatic close_pass();
    int exp_corr;
    int exp_uncorr;
    logic [6:0] syn;
    exp_corr   = 0;
    exp_uncorr = 0;
    for (int a = 0; a < BankSize; a++) begin
      syn = ref_syndrome(shadow[a]);
      if (^syn) exp_corr++;
      else if (syn != '0) exp_uncorr++;
    end
    // Nothing may be corrected while the trigger is low
    if (phase_i == PhTrigOff) begin
      exp_corr   = 0;
      exp_uncorr = 0;
    end
    if (phase_i != PhInterf) begin
      check_cnt_o++;
      if (corr_cnt != exp_corr || uncorr_cnt != exp_uncorr) begin
        report_error($sformatf("pass pulses corrected %0d/%0d uncorrectable %0d/%0d",
                               corr_cnt, exp_corr, uncorr_cnt, exp_uncorr));
      end
    end
    if (phase_i != PhTrigOff) begin
      for (int a = 0; a < BankSize; a++) shadow[a] = ref_scrub(shadow[a]);
    end
    corr_cnt   = 0;
    uncorr_cnt = 0;
  endtask

  initial begin : proc_init
    check_cnt_o = 0;
    err_cnt_o   = 0;
    corr_cnt    = 0;
    uncorr_cnt  = 0;
    rd_pending  = 1'b0;
    rd_addr     = 0;
  end

  // Sample on the falling edge, halfway between stimulus edges
  always @(negedge clk_i) begin : proc_compare
    codeword_t exp_cw;
    if (rst_ni) begin
      if (rd_pending) begin
        exp_cw = shadow[rd_addr];
        check_cnt_o++;
        // During scrubbing the word may already be corrected
        if (intc_rdata_i !== exp_cw &&
            !(phase_i == PhInterf && intc_rdata_i === ref_scrub(exp_cw))) begin
          report_error($sformatf("read addr %0d got %h expected %h",
                                 rd_addr, intc_rdata_i, exp_cw));
        end
      end
      if (bit_corrected_i) corr_cnt++;
      if (uncorrectable_i) uncorr_cnt++;
      if (pass_done_i) close_pass();
      rd_pending = intc_req_i.req && !intc_req_i.we;
      rd_addr    = int'(intc_req_i.addr) % BankSize;
      if (intc_req_i.req && intc_req_i.we) begin
        shadow[int'(intc_req_i.addr) % BankSize] = intc_req_i.wdata;
      end
    end
  end

endmodule

// ==== verification/tb_clk_gen.sv ====
//////////////////////////////
// Testbench clock and reset
//////////////////////////////

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin : proc_clk
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset released on a falling edge, away from the sampling edge
  initial begin : proc_rst
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== src/ecc_scrub_bank_top.sv ====
//////////////////////////////
// ECC scrubbed bank
// Bank, SECDED coders and scrubber
//////////////////////////////

module ecc_scrub_bank_top #(
  parameter int unsigned BankSize = 256
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     scrub_trigger_i,
  input  ecc_scrub_pkg::bank_req_t intc_req_i,
  output ecc_scrub_pkg::codeword_t intc_rdata_o,
  output logic                     bit_corrected_o,
  output logic                     uncorrectable_o
);
  import ecc_scrub_pkg::*;

  bank_req_t bank_req;
  codeword_t dec_in;
  data_t     dec_data;
  ecc_err_t  dec_err;
  codeword_t enc_code;

  // Arbitration and scrub control
  ecc_scrubber #(
    .BankSize(BankSize)
  ) i_scrubber (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .scrub_trigger_i(scrub_trigger_i),
    .intc_req_i     (intc_req_i),
    .bank_req_o     (bank_req),
    .bank_rdata_i   (intc_rdata_o),
    .dec_in_o       (dec_in),
    .dec_err_i      (dec_err),
    .enc_in_i       (enc_code),
    .bit_corrected_o(bit_corrected_o),
    .uncorrectable_o(uncorrectable_o)
  );

  secded_dec i_dec (
    .code_i(dec_in),
    .data_o(dec_data),
    .err_o (dec_err)
  );

  // Corrected data re-encoded for write-back
  secded_enc i_enc (
    .data_i(dec_data),
    .code_o(enc_code)
  );

  // Read data feeds both the outside port and the scrubber
  ecc_bank #(
    .BankSize(BankSize)
  ) i_bank (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (bank_req),
    .rdata_o(intc_rdata_o)
  );

endmodule

// ==== src/ecc_bank.sv ====
//////////////////////////////
// Codeword bank
// Single port, registered read
//////////////////////////////

module ecc_bank #(
  parameter int unsigned BankSize = 256
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  ecc_scrub_pkg::bank_req_t req_i,
  output ecc_scrub_pkg::codeword_t rdata_o
);
  import ecc_scrub_pkg::*;

  localparam int unsigned AddrWidth = $clog2(BankSize);

  codeword_t            mem_q [BankSize];
  logic [AddrWidth-1:0] addr;

  // Only the low address bits select a word
  assign addr = req_i.addr[AddrWidth-1:0];

  always_ff @(posedge clk_i) begin : proc_write
    if (req_i.req && req_i.we) begin
      mem_q[addr] <= req_i.wdata;
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_read
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i.req && !req_i.we) begin
      rdata_o <= mem_q[addr];
    end
  end

endmodule

// ==== src/ecc_scrubber.sv ====
//////////////////////////////
// ECC scrubber
// Walks the bank, writes back corrected words
//////////////////////////////

module ecc_scrubber #(
  parameter int unsigned BankSize = 256
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Level, scrubbing runs while high
  input  logic                     scrub_trigger_i,
  input  ecc_scrub_pkg::bank_req_t intc_req_i,

  output ecc_scrub_pkg::bank_req_t bank_req_o,
  input  ecc_scrub_pkg::codeword_t bank_rdata_i,

  // Decoder and encoder loop
  output ecc_scrub_pkg::codeword_t dec_in_o,
  input  ecc_scrub_pkg::ecc_err_t  dec_err_i,
  input  ecc_scrub_pkg::codeword_t enc_in_i,

  output logic                     bit_corrected_o,
  output logic                     uncorrectable_o
);
  import ecc_scrub_pkg::*;

  localparam int unsigned AddrWidth = $clog2(BankSize);

  scrub_state_e         state_d, state_q;
  logic [AddrWidth-1:0] ptr_d, ptr_q;
  logic [AddrWidth-1:0] ptr_next;
  logic                 scrub_req;
  logic                 scrub_we;
  bank_req_t            scrub_bank_req;

  // Registered read data goes straight into the decoder
  assign dec_in_o = bank_rdata_i;

  // Pointer wraps at the last word
  assign ptr_next = (ptr_q == AddrWidth'(BankSize - 1)) ? '0 : ptr_q + 1'b1;

  always_comb begin : proc_scrub_req
    scrub_bank_req       = '0;
    scrub_bank_req.req   = scrub_req;
    scrub_bank_req.we    = scrub_we;
    // Zero-extend the pointer into the address field
    scrub_bank_req.addr[AddrWidth-1:0] = ptr_q;
    // Re-encoded corrected word
    scrub_bank_req.wdata = enc_in_i;
  end

  always_comb begin : proc_bank_mux
    // Outside port owns the bank by default
    bank_req_o = intc_req_i;
    // Scrubber gets it only while busy and the outside is idle
    if ((state_q == Read || state_q == Write) && !intc_req_i.req) begin
      bank_req_o = scrub_bank_req;
    end
    bank_req_o.req = intc_req_i.req | scrub_req;
  end

  always_comb begin : proc_fsm
    state_d         = state_q;
    ptr_d           = ptr_q;
    scrub_req       = 1'b0;
    scrub_we        = 1'b0;
    bit_corrected_o = 1'b0;
    uncorrectable_o = 1'b0;

    unique case (state_q)
      Idle: begin
        if (scrub_trigger_i) begin
          state_d = Read;
        end
      end

      Read: begin
        scrub_req = 1'b1;
        // Outside traffic stretches this state
        if (!intc_req_i.req) begin
          state_d = Write;
        end
      end

      Write: begin
        // Write back only a correctable word
        scrub_req = dec_err_i.single;
        scrub_we  = dec_err_i.single;
        if (intc_req_i.req) begin
          // Outside interfered, read the same word again
          state_d = Read;
        end else begin
          state_d         = Idle;
          ptr_d           = ptr_next;
          bit_corrected_o = dec_err_i.single;
          // Double error, word left untouched
          uncorrectable_o = dec_err_i.double;
        end
      end

      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_state
    if (!rst_ni) begin
      state_q <= Idle;
      ptr_q   <= '0;
    end else begin
      state_q <= state_d;
      ptr_q   <= ptr_d;
    end
  end

endmodule

// ==== src/secded_dec.sv ====
//////////////////////////////
// Hsiao 39/32 decoder
// Corrects one bit error, flags two
//////////////////////////////

module secded_dec (
  input  ecc_scrub_pkg::codeword_t code_i,
  output ecc_scrub_pkg::data_t     data_o,
  output ecc_scrub_pkg::ecc_err_t  err_o
);
  import ecc_scrub_pkg::*;

  // Same H-matrix columns as the encoder
  localparam syndrome_t HCol [DataWidth] = '{
    7'h07, 7'h0b, 7'h13, 7'h23, 7'h43, 7'h0d, 7'h15, 7'h25,
    7'h45, 7'h19, 7'h29, 7'h49, 7'h31, 7'h51, 7'h61, 7'h0e,
    7'h16, 7'h26, 7'h46, 7'h1a, 7'h2a, 7'h4a, 7'h32, 7'h52,
    7'h62, 7'h1c, 7'h2c, 7'h4c, 7'h34, 7'h54, 7'h64, 7'h38
  };

  syndrome_t par;
  syndrome_t syndrome;
  logic      single_err;
  logic      double_err;

  always_comb begin : proc_syndrome
    par = '0;
    // Recompute check bits from the stored data
    for (int unsigned j = 0; j < DataWidth; j++) begin
      par ^= HCol[j] & {ParWidth{code_i[j]}};
    end
    // Compare with the stored check bits
    syndrome = par ^ code_i[CodeWidth-1:DataWidth];
  end

  // Odd syndrome weight, one flipped bit
  assign single_err = ^syndrome;
  // Even nonzero weight, two flipped bits
  assign double_err = (|syndrome) & ~(^syndrome);

  assign err_o.single = single_err;
  assign err_o.double = double_err;

  always_comb begin : proc_correct
    data_o = code_i[DataWidth-1:0];
    for (int unsigned j = 0; j < DataWidth; j++) begin
      // Syndrome equal to a data column points at that bit
      if (single_err && (syndrome == HCol[j])) begin
        data_o[j] = ~code_i[j];
      end
    end
    // A unit syndrome is a check bit error, data passes as is
  end

endmodule

// ==== src/secded_enc.sv ====
//////////////////////////////
// Hsiao 39/32 encoder
// Appends 7 check bits to 32 data bits
//////////////////////////////

module secded_enc (
  input  ecc_scrub_pkg::data_t     data_i,
  output ecc_scrub_pkg::codeword_t code_o
);
  import ecc_scrub_pkg::*;

  // H-matrix column of each data bit
  // Every column is a distinct weight-3 pattern, check bits use the unit columns
  localparam syndrome_t HCol [DataWidth] = '{
    7'h07, 7'h0b, 7'h13, 7'h23, 7'h43, 7'h0d, 7'h15, 7'h25,
    7'h45, 7'h19, 7'h29, 7'h49, 7'h31, 7'h51, 7'h61, 7'h0e,
    7'h16, 7'h26, 7'h46, 7'h1a, 7'h2a, 7'h4a, 7'h32, 7'h52,
    7'h62, 7'h1c, 7'h2c, 7'h4c, 7'h34, 7'h54, 7'h64, 7'h38
  };

  syndrome_t par;

  always_comb begin : proc_parity
    par = '0;
    for (int unsigned j = 0; j < DataWidth; j++) begin
      // Data bit j toggles every check bit its column selects
      par ^= HCol[j] & {ParWidth{data_i[j]}};
    end
  end

  // Check bits on top, data unchanged below
  assign code_o = {par, data_i};

endmodule

// ==== src/ecc_scrub_pkg.sv ====
//////////////////////////////
// ECC scrub package
// Codeword, error and bank access types
//////////////////////////////

package ecc_scrub_pkg;

  // Hsiao 39/32 code dimensions
  localparam int unsigned CodeWidth = 39;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned ParWidth  = 7;

  // Check bits sit above the data bits
  typedef logic [CodeWidth-1:0] codeword_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [ParWidth-1:0]  syndrome_t;

  // Decoder verdict, at most one flag set
  typedef struct packed {
    logic double;
    logic single;
  } ecc_err_t;

  // One access to the bank
  // Same shape for the outside port and the bank port
  typedef struct packed {
    logic        req;
    logic        we;
    // Word address, upper bits beyond the bank size are ignored
    logic [15:0] addr;
    codeword_t   wdata;
  } bank_req_t;

  // Scrubber FSM states
  typedef enum logic [1:0] {
    Idle,
    Read,
    Write
  } scrub_state_e;

endpackage
